// ==== bench/cmp_fiber_rx_checker.sv ====
`timescale 1ns/100ps

module cmp_fiber_rx_checker (
  input logic                           CMP_RX_CLK160,
  input logic                           cmp_rx_resetdone,
  input logic                           sync_done,
  input logic                           ttc_resync,
  input logic                           force_error,
  input cmp_fiber_rx_pkg::rx_symbol_t   rx_sym,
  input cmp_fiber_rx_pkg::rx_frame_t    rcv_frame,
  input cmp_fiber_rx_pkg::frame_data_t  prompt_data,
  input cmp_fiber_rx_pkg::link_status_t link
);

  cmp_fiber_rx_pkg::rx_word_t   data_h [1:4];    // Input words, 1 = last cycle
  logic [1:0]                   isk_h [1:8];
  logic [4:1]                   clr_h;           // Resync clear history
  logic [3:1]                   fe_h;            // force_error history
  cmp_fiber_rx_pkg::err_count_t cnt_h;           // errcount one cycle back
  logic [7:0]                   up_cycles;       // Cycles since last clear
  logic                         clear_in;
  logic                         frame_end;       // Cycle after a phase 3 word
  logic                         idle_prev;       // No phase in the last cycle
  bit                           fail_frame  = 1'b0;
  bit                           fail_prompt = 1'b0;
  bit                           fail_idle   = 1'b0;
  bit                           fail_ltncy  = 1'b0;
  bit                           fail_acq    = 1'b0;
  bit                           fail_loss   = 1'b0;
  bit                           fail_inj    = 1'b0;
  bit                           fail_sat    = 1'b0;
  bit                           fail_bad    = 1'b0;
  bit                           fail_sync   = 1'b0;
  logic                         any_fail;

  assign clear_in = !sync_done || ttc_resync;

  // --------------------
  // Input history
  // --------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      for (int i = 1; i <= 4; i++) data_h[i] <= '0;
      for (int i = 1; i <= 8; i++) isk_h[i] <= 2'b00;
      clr_h     <= '0;
      fe_h      <= '0;
      cnt_h     <= '0;
      up_cycles <= '0;
    end else begin
      data_h[1] <= rx_sym.data;
      isk_h[1]  <= rx_sym.isk;
      for (int i = 2; i <= 4; i++) data_h[i] <= data_h[i-1];
      for (int i = 2; i <= 8; i++) isk_h[i] <= isk_h[i-1];
      clr_h     <= {clr_h[3:1], clear_in};
      fe_h      <= {fe_h[2:1], force_error};
      cnt_h     <= link.errcount;
      if (clear_in)
        up_cycles <= '0;
      else if (up_cycles != 8'hFF)
        up_cycles <= up_cycles + 1'b1;          // Saturating
    end
  end

  // K four back with three data words since
  // No stray K that could pre-empt a slot
  assign frame_end = (isk_h[4] == 2'b01) && (isk_h[3] == 2'b00) && (isk_h[2] == 2'b00)
                     && (isk_h[1] == 2'b00) && (isk_h[5] != 2'b01) && (isk_h[6] != 2'b01)
                     && (isk_h[7] != 2'b01) && (clr_h[3:1] == 3'b000);
  assign idle_prev = (isk_h[2] != 2'b01) && (isk_h[3] != 2'b01) && (isk_h[4] != 2'b01)
                     && (isk_h[5] != 2'b01);

  // --------------------
  // Frame output
  // --------------------
  a_frame: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    frame_end |-> (rcv_frame.data == {data_h[1], data_h[2], data_h[3]})
                  && (rcv_frame.nonzero == {|data_h[1], |data_h[2], |data_h[3]}))
    else begin
      fail_frame = 1'b1;
      $error("FAIL %0t: frame data or nonzero wrong", $time);
    end

  // Live word on top of the two held data words
  a_prompt: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    frame_end |-> (prompt_data == {rx_sym.data, data_h[2], data_h[3]}))
    else begin
      fail_prompt = 1'b1;
      $error("FAIL %0t: prompt data wrong", $time);
    end

  a_idle: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    idle_prev |-> (rcv_frame.data == '0))
    else begin
      fail_idle = 1'b1;
      $error("FAIL %0t: frame data not cleared", $time);
    end

  // The K-word is latched at phase 0 and so needs the previous frame
  a_ltncy: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    (frame_end && (isk_h[8] == 2'b01) && !clr_h[4])
      |-> (rcv_frame.ltncy_trig == (data_h[4][7:0] == cmp_fiber_rx_pkg::ltncy_byte))
          && (rcv_frame.kchar == data_h[4]))
    else begin
      fail_ltncy = 1'b1;
      $error("FAIL %0t: latency trigger or kchar wrong", $time);
    end

  // --------------------
  // Link status
  // --------------------
  a_acq: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    link.good |-> (up_cycles >= 8'd64))       // 16 frame periods
    else begin
      fail_acq = 1'b1;
      $error("FAIL %0t: link good too early", $time);
    end

  a_loss: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    ($fell(link.good) && !clr_h[1])
      |-> link.had_err && ((link.errcount == cnt_h + 1'b1)
                           || (cnt_h[7:0] == cmp_fiber_rx_pkg::err_sat)))
    else begin
      fail_loss = 1'b1;
      $error("FAIL %0t: link loss not counted", $time);
    end

  a_inj: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    (fe_h[3] && !fe_h[2] && !clr_h[1] && (cnt_h[7:0] != cmp_fiber_rx_pkg::err_sat))
      |-> (link.errcount == cnt_h + 1'b1))
    else begin
      fail_inj = 1'b1;
      $error("FAIL %0t: injected error not counted", $time);
    end

  a_sat: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    ((cnt_h[7:0] == cmp_fiber_rx_pkg::err_sat) && !clr_h[1]) |-> (link.errcount == cnt_h))
    else begin
      fail_sat = 1'b1;
      $error("FAIL %0t: error count passed saturation", $time);
    end

  a_bad: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    link.bad == cnt_h[7])
    else begin
      fail_bad = 1'b1;
      $error("FAIL %0t: link bad not errcount bit 7", $time);
    end

  a_sync: assert property (@(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    (clr_h[2] && clr_h[1]) |-> ((link.errcount == '0) && !link.good))
    else begin
      fail_sync = 1'b1;
      $error("FAIL %0t: resync did not clear link", $time);
    end

  assign any_fail = fail_frame || fail_prompt || fail_idle || fail_ltncy || fail_acq
                    || fail_loss || fail_inj || fail_sat || fail_bad || fail_sync;

endmodule

bind cmp_fiber_rx cmp_fiber_rx_checker checker0 (
  .CMP_RX_CLK160    (CMP_RX_CLK160),
  .cmp_rx_resetdone (cmp_rx_resetdone),
  .sync_done        (sync_done),
  .ttc_resync       (ttc_resync),
  .force_error      (force_error),
  .rx_sym           (rx_sym),
  .rcv_frame        (rcv_frame),
  .prompt_data      (prompt_data),
  .link             (link)
);

// ==== bench/cmp_fiber_rx_tb.sv ====
`timescale 1ns/100ps

module cmp_fiber_rx_tb;

  logic                           CMP_RX_CLK160;
  logic                           cmp_rx_resetdone;
  logic                           sync_done;
  logic                           ttc_resync;
  logic                           force_error;
  cmp_fiber_rx_pkg::rx_symbol_t   rx_sym;
  cmp_fiber_rx_pkg::rx_frame_t    rcv_frame;
  cmp_fiber_rx_pkg::frame_data_t  prompt_data;
  cmp_fiber_rx_pkg::link_status_t link;
  integer                         seed;
  int                             n;
  cmp_fiber_rx_pkg::err_count_t   cnt_before;

  cmp_fiber_rx dut0 (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .sync_done        (sync_done),
    .ttc_resync       (ttc_resync),
    .force_error      (force_error),
    .rx_sym           (rx_sym),
    .rcv_frame        (rcv_frame),
    .prompt_data      (prompt_data),
    .link             (link)
  );

  initial CMP_RX_CLK160 = 1'b0;
  always #20 CMP_RX_CLK160 = ~CMP_RX_CLK160;   // 25 MHz stand-in for 160

  // Watch the checker flags every cycle
  always @(posedge CMP_RX_CLK160) begin
    if (dut0.checker0.any_fail === 1'b1) begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "A checker assertion failed");
    end
  end

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Timeout");
  endtask

  // One symbol driven 2 ns after the edge
  task automatic send_word(input cmp_fiber_rx_pkg::rx_word_t w, input logic [1:0] isk,
                           input logic [1:0] ntab);
    @(posedge CMP_RX_CLK160);
    #2;
    rx_sym.data       = w;
    rx_sym.isk        = isk;
    rx_sym.notintable = ntab;
    rx_sym.lossofsync = 1'b0;
  endtask

  // K-word then three random data words
  // Negative bad_slot gives a clean frame
  task automatic send_frame(input bit fc, input int bad_slot, input bit nit);
    logic [31:0]                r;
    cmp_fiber_rx_pkg::rx_word_t w;
    logic [1:0]                 isk;
    logic [1:0]                 ntab;
    for (int i = 0; i < 4; i++) begin
      r    = $random(seed);
      w    = r[15:0];
      isk  = 2'b00;
      ntab = 2'b00;
      if (i == 0) begin
        w[7:0] = fc ? cmp_fiber_rx_pkg::ltncy_byte : cmp_fiber_rx_pkg::comma_byte;
        isk    = 2'b01;
      end
      if (i == bad_slot) begin
        if (nit)
          ntab = 2'b01;                    // Code violation
        else if (i == 0)
          w[7:0] = 8'h00;                  // K flag kept with a broken EOF pattern
        else
          isk = 2'b10;                     // K bit in the payload
      end
      send_word(w, isk, ntab);
    end
  endtask

  initial begin
    seed             = 32'h5d287a66;
    cmp_rx_resetdone = 1'b0;
    sync_done        = 1'b0;
    ttc_resync       = 1'b0;
    force_error      = 1'b0;
    rx_sym           = '0;
    repeat (16) @(posedge CMP_RX_CLK160);
    #2 cmp_rx_resetdone = 1'b1;
    repeat (4) @(posedge CMP_RX_CLK160);
    #2 sync_done = 1'b1;

    // --------------------
    // Link acquisition
    // --------------------
    n = 0;
    while (!link.good) begin
      if (n == 20)
        report_timeout("link good after clean frames");
      send_frame(n % 5 == 3, -1, 1'b0);    // Every fifth frame asks for latency
      n++;
    end
    send_frame(1'b1, -1, 1'b0);
    send_frame(1'b0, -1, 1'b0);

    // Corrupted frame takes the link down
    send_frame(1'b0, 2, 1'b0);
    n = 0;
    while (link.good || !link.had_err) begin
      if (n == 2)
        report_timeout("link loss after a corrupted frame");
      send_frame(1'b0, -1, 1'b0);
      n++;
    end
    send_frame(1'b0, 1, 1'b1);             // notintable in a data slot
    send_frame(1'b0, 0, 1'b0);             // Broken K-word
    for (int i = 0; i < 8; i++)
      send_word('0, 2'b00, 2'b00);         // Gap that stops the framing

    // --------------------
    // Error injection up to saturation
    // --------------------
    for (int t = 0; t < 256; t++) begin
      cnt_before = link.errcount;
      @(posedge CMP_RX_CLK160);
      #2 force_error = 1'b1;
      repeat (2) @(posedge CMP_RX_CLK160);
      #2 force_error = 1'b0;
      n = 0;
      while ((link.errcount == cnt_before) && (cnt_before[7:0] != cmp_fiber_rx_pkg::err_sat)) begin
        if (n == 4)
          report_timeout("error count after force_error");
        @(posedge CMP_RX_CLK160);
        #2;
        n++;
      end
    end

    // --------------------
    // Link back up before resync
    // --------------------
    n = 0;
    while (!link.good) begin
      if (n == 20)
        report_timeout("link good again before resync");
      send_frame(1'b0, -1, 1'b0);
      n++;
    end

    // Resync of a good link clears the counter and the link
    @(posedge CMP_RX_CLK160);
    #2 ttc_resync = 1'b1;
    n = 0;
    while ((link.errcount != '0) || link.good) begin
      if (n == 4)
        report_timeout("resync clear");
      @(posedge CMP_RX_CLK160);
      #2;
      n++;
    end
    repeat (3) @(posedge CMP_RX_CLK160);
    #2 ttc_resync = 1'b0;
    send_frame(1'b0, -1, 1'b0);
    send_frame(1'b1, -1, 1'b0);
    repeat (4) @(posedge CMP_RX_CLK160);
    #2;

    if (!dut0.checker0.any_fail) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "A checker assertion failed");
    end
  end

endmodule

// ==== cmp_fiber_rx.f ====
logic/cmp_fiber_rx_pkg.sv
logic/frame_capture.sv
logic/link_monitor.sv
logic/cmp_fiber_rx.sv
bench/cmp_fiber_rx_checker.sv
bench/cmp_fiber_rx_tb.sv

// ==== logic/cmp_fiber_rx.sv ====
`timescale 1ns/100ps

module cmp_fiber_rx (
  input  logic                           CMP_RX_CLK160,
  input  logic                           cmp_rx_resetdone,
  input  logic                           sync_done,
  input  logic                           ttc_resync,
  input  logic                           force_error,
  input  cmp_fiber_rx_pkg::rx_symbol_t   rx_sym,
  output cmp_fiber_rx_pkg::rx_frame_t    rcv_frame,
  output cmp_fiber_rx_pkg::frame_data_t  prompt_data,
  output cmp_fiber_rx_pkg::link_status_t link
);

  logic                          resync_clear;
  cmp_fiber_rx_pkg::word_phase_t phase;        // Slot strobes to the monitor

  // Phase alignment not done yet, or a TTC resync
  assign resync_clear = !sync_done || ttc_resync;

  // --------------------
  // Frame decode
  // --------------------
  frame_capture frame_capture0 (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .resync_clear     (resync_clear),
    .rx_sym           (rx_sym),
    .phase            (phase),
    .rcv_frame        (rcv_frame),
    .prompt_data      (prompt_data)
  );

  // --------------------
  // Link health
  // --------------------
  link_monitor link_monitor0 (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .resync_clear     (resync_clear),
    .rx_sym           (rx_sym),
    .phase            (phase),
    .force_error      (force_error),   // Async, synchronised inside
    .link             (link)
  );

endmodule

// ==== logic/cmp_fiber_rx_pkg.sv ====
package cmp_fiber_rx_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int word_w      = 16;                  // One symbol pair per clock
  localparam int frame_words = 3;                   // Payload words per bunch crossing
  localparam int frame_w     = word_w * frame_words; // 48 bit payload
  localparam int err_cnt_w   = 16;                  // Link error counter

  // --------------------
  // Symbol constants
  // --------------------
  localparam logic [7:0] comma_byte   = 8'hBC;      // Normal frame-end K28.5
  localparam logic [7:0] ltncy_byte   = 8'hFC;      // K28.7, requests latency trigger

  // Bits 4:1 of every legal end-of-frame K character
  // BC, 1C, 3C, 5C, 7C, 9C, DC and FD all match
  localparam logic [3:0] eof_mask_val = 4'hE;

  // --------------------
  // Link monitor limits
  // --------------------
  localparam int         good_frames  = 15;         // Clean frames before link good
  localparam logic [7:0] err_sat      = 8'hFE;      // Error count stops here

  // Plain vectors
  typedef logic [word_w-1:0]    rx_word_t;
  typedef logic [frame_w-1:0]   frame_data_t;
  typedef logic [err_cnt_w-1:0] err_count_t;

  // One-hot strobes, bit 0 is the K-word slot
  typedef logic [3:0]           word_phase_t;

  // Decoded receiver output, one per clock
  typedef struct packed {
    rx_word_t   data;                               // Two decoded bytes
    logic [1:0] isk;                                // K flag per byte
    logic [1:0] notintable;                         // Code violation per byte
    logic       lossofsync;                         // Receiver sync lost
  } rx_symbol_t;

  // Assembled frame
  typedef struct packed {
    frame_data_t data;                              // {w3, w2, w1}
    rx_word_t    kchar;                             // K-word that opened the frame
    logic [3:1]  nonzero;                           // Per data word OR-reduce
    logic        ltncy_trig;                        // FC comma seen
  } rx_frame_t;

  // Link health
  typedef struct packed {
    logic       good;                               // 15 clean frames in a row
    logic       bad;                                // Error count bit 7
    logic       had_err;                            // Went down or never came up
    err_count_t errcount;
  } link_status_t;

endpackage

// ==== logic/frame_capture.sv ====
`timescale 1ns/100ps

module frame_capture (
  input  logic                          CMP_RX_CLK160,
  input  logic                          cmp_rx_resetdone,
  input  logic                          resync_clear,
  input  cmp_fiber_rx_pkg::rx_symbol_t  rx_sym,
  output cmp_fiber_rx_pkg::word_phase_t phase,
  output cmp_fiber_rx_pkg::rx_frame_t   rcv_frame,
  output cmp_fiber_rx_pkg::frame_data_t prompt_data
);

  logic                       k_slot;     // Low byte carries a K character
  logic                       ltncy_k;    // ... and it is the latency comma
  cmp_fiber_rx_pkg::rx_word_t w0_reg;     // K-word of the frame in flight
  cmp_fiber_rx_pkg::rx_word_t w1_reg;     // First data word
  cmp_fiber_rx_pkg::rx_word_t w2_reg;     // Second data word
  logic                       lt_latch;   // Latency request from w0

  // Only isk is looked at here, any K character starts the phase chain
  assign k_slot  = (rx_sym.isk == 2'b01);
  assign ltncy_k = k_slot && (rx_sym.data[7:0] == cmp_fiber_rx_pkg::ltncy_byte);

  // --------------------
  // Word phase strobes
  // --------------------
  // K at t gives phase 1 at t+1 ... phase 0 at t+4
  // Not touched by resync, the stream keeps its framing
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      phase <= '0;
    end else begin
      phase[1] <= k_slot;                 // First data slot follows the comma
      phase[2] <= phase[1];
      phase[3] <= phase[2];
      phase[0] <= phase[3];               // Next frame's K-word
    end
  end

  // --------------------
  // Frame assembly
  // --------------------
  // Priority chain, phase 0 first and phase 3 last
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      w0_reg    <= '0;
      w1_reg    <= '0;
      w2_reg    <= '0;
      lt_latch  <= 1'b0;
      rcv_frame <= '0;
    end else if (resync_clear) begin
      rcv_frame <= '0;                    // Holding registers left as they are
    end else begin
      if (phase[0]) begin
        w0_reg   <= rx_sym.data;          // Remember the K-word for kchar
        lt_latch <= ltncy_k;
      end else if (phase[1]) begin
        w1_reg               <= rx_sym.data;
        rcv_frame.nonzero[1] <= |rx_sym.data;
      end else if (phase[2]) begin
        w2_reg               <= rx_sym.data;
        rcv_frame.nonzero[2] <= |rx_sym.data;
      end else if (phase[3]) begin
        // Latest word on top
        rcv_frame.data       <= {rx_sym.data, w2_reg, w1_reg};
        rcv_frame.kchar      <= w0_reg;
        rcv_frame.ltncy_trig <= lt_latch;
        rcv_frame.nonzero[3] <= |rx_sym.data;
      end else begin
        rcv_frame <= '0;                  // No framing, drop everything
      end
    end
  end

  // Unregistered view, word 3 straight off the receiver
  assign prompt_data = {rx_sym.data, w2_reg, w1_reg};

endmodule

// ==== logic/link_monitor.sv ====
`timescale 1ns/100ps

module link_monitor (
  input  logic                           CMP_RX_CLK160,
  input  logic                           cmp_rx_resetdone,
  input  logic                           resync_clear,
  input  cmp_fiber_rx_pkg::rx_symbol_t   rx_sym,
  input  cmp_fiber_rx_pkg::word_phase_t  phase,
  input  logic                           force_error,
  output cmp_fiber_rx_pkg::link_status_t link
);

  // Counter just wide enough for good_frames
  localparam int cnt_w = $clog2(cmp_fiber_rx_pkg::good_frames + 1);
  typedef logic [cnt_w-1:0] frame_cnt_t;

  logic                            sym_clean;    // No sync loss, no code violation
  logic                            k_ok;         // Legal end-of-frame K-word
  logic                            d_ok;         // Legal data word
  logic [3:0]                      mon_in;       // One check bit per slot
  logic                            mon_rst;      // Last frame not clean
  frame_cnt_t                      frame_cnt;
  logic                            link_good;
  logic                            link_err;     // Sticky went-down flag
  logic                            link_bad;
  logic                            went_down;
  logic [1:0]                      force_err_sr; // Two-flop synchroniser
  logic                            err_inj;
  cmp_fiber_rx_pkg::err_count_t    err_count;

  // --------------------
  // Per-word qualification
  // --------------------
  assign sym_clean = !rx_sym.lossofsync && (rx_sym.notintable == 2'b00);
  assign k_ok      = sym_clean && (rx_sym.isk == 2'b01)
                     && (rx_sym.data[4:1] == cmp_fiber_rx_pkg::eof_mask_val);
  assign d_ok      = sym_clean && (rx_sym.isk == 2'b00);   // No K bits in payload

  assign went_down = link_good && mon_rst;   // Was good, last frame was not

  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      mon_in    <= 4'h0;
      mon_rst   <= 1'b1;                     // Link starts out unproven
      frame_cnt <= '0;
      link_good <= 1'b0;
      link_err  <= 1'b0;
    end else if (resync_clear) begin
      mon_in    <= 4'h0;
      mon_rst   <= 1'b1;
      frame_cnt <= '0;
      link_good <= 1'b0;
      link_err  <= 1'b0;
    end else begin
      if (phase[0])
        mon_in[0] <= k_ok;
      else if (phase[1])
        mon_in[1] <= d_ok;
      else if (phase[2])
        mon_in[2] <= d_ok;
      else if (phase[3])
        mon_in[3] <= d_ok;
      else
        mon_in <= 4'h0;                      // Lost framing, fails next compare

      mon_rst <= (mon_in != 4'hF);

      // Count clean frames, stop once good
      if (mon_rst)
        frame_cnt <= '0;
      else if (!link_good && phase[3])
        frame_cnt <= frame_cnt + 1'b1;

      link_good <= !mon_rst && (frame_cnt == frame_cnt_t'(cmp_fiber_rx_pkg::good_frames));

      if (went_down)
        link_err <= 1'b1;                    // Held until resync
    end
  end

  // --------------------
  // Error injection and count
  // --------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone)
      force_err_sr <= 2'b00;
    else
      force_err_sr <= {force_err_sr[0], force_error};
  end

  assign err_inj = (force_err_sr == 2'b10);  // Falling edge of the synced level

  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      err_count <= '0;
    end else if (resync_clear) begin
      err_count <= '0;
    end else if ((err_inj || went_down) && (err_count[7:0] != cmp_fiber_rx_pkg::err_sat)) begin
      err_count <= err_count + 1'b1;         // Saturates on the low byte
    end
  end

  // Bad once 128 errors seen
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone)
      link_bad <= 1'b0;
    else
      link_bad <= err_count[7];
  end

  assign link.good     = link_good;
  assign link.bad      = link_bad;
  assign link.had_err  = link_err || mon_rst;  // Also high while never up
  assign link.errcount = err_count;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the cmp_fiber_rx testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cmp_fiber_rx_tb \
  -f cmp_fiber_rx.f \
  -o cmp_fiber_rx_sim

./obj_dir/cmp_fiber_rx_sim +verilator+error+limit+100
